// ==== logic/floor_pkg.sv ====
/*
 * Shared definitions for the elevator request logic
 * Floor count and widths, floor and mask types, car state and direction enums
 * Helper functions for stop detection and floor masks
 */

`default_nettype none

package floor_pkg;

    localparam int NUM_FLOORS = 11;
    localparam int FLOOR_W    = 4;
    localparam int STATE_W    = 6;

    typedef logic [FLOOR_W-1:0]    floor_t;
    typedef logic [NUM_FLOORS-1:0] floor_mask_t;

    // Motion controller state codes
    typedef enum logic [STATE_W-1:0] {
        STOP_FL1 = 6'h00, STOP_FL2, STOP_FL3, STOP_FL4,
        STOP_FL5, STOP_FL6, STOP_FL7, STOP_FL8,
        STOP_FL9, STOP_FL10, STOP_FL11,
        UP_F1_F2 = 6'h0B, UP_F2_F3, UP_F3_F4, UP_F4_F5,
        UP_F5_F6, UP_F6_F7, UP_F7_F8, UP_F8_F9,
        UP_F9_F10, UP_F10_F11,
        DOWN_F11_F10 = 6'h15, DOWN_F10_F9, DOWN_F9_F8, DOWN_F8_F7,
        DOWN_F7_F6, DOWN_F6_F5, DOWN_F5_F4, DOWN_F4_F3,
        DOWN_F3_F2, DOWN_F2_F1,
        EMERGENCY = 6'h1F
    } car_state_e;

    typedef enum logic {
        DIR_DOWN = 1'b0,
        DIR_UP   = 1'b1
    } dir_e;

    // Stop codes sit at the bottom of the encoding
    function automatic logic is_stop_state(input car_state_e s);
        return (s <= STOP_FL11);
    endfunction

    // Floors strictly above f
    function automatic floor_mask_t floors_above(input floor_t f);
        floor_mask_t m;
        for (int n = 0; n < NUM_FLOORS; n++) begin
            m[n] = (floor_t'(n) > f);
        end
        return m;
    endfunction

    // Floors strictly below f
    function automatic floor_mask_t floors_below(input floor_t f);
        floor_mask_t m;
        for (int n = 0; n < NUM_FLOORS; n++) begin
            m[n] = (floor_t'(n) < f);
        end
        return m;
    endfunction

    // One-hot mask of a single floor
    function automatic floor_mask_t floor_bit(input floor_t f);
        return floor_mask_t'(1) << f;
    endfunction

endpackage

`default_nettype wire

// ==== logic/request_ctrl_if.sv ====
/*
 * Request bus between the call registers and the dispatcher
 * Power acceptance, arrival clear and the three pending masks
 */

`timescale 1ns/1ps
`default_nettype none

interface request_ctrl_if import floor_pkg::*; ();

    // From the dispatcher
    logic        accept;
    logic        arrive;
    floor_t      arrive_floor;

    // From the hall call register
    floor_mask_t up_pending;
    floor_mask_t down_pending;

    // From the car call register
    floor_mask_t car_pending;

    modport hall_side (
        input  accept,
        input  arrive,
        input  arrive_floor,
        output up_pending,
        output down_pending
    );

    modport car_side (
        input  accept,
        input  arrive,
        input  arrive_floor,
        output car_pending
    );

    modport dispatch_side (
        output accept,
        output arrive,
        output arrive_floor,
        input  up_pending,
        input  down_pending,
        input  car_pending
    );

endinterface

`default_nettype wire

// ==== logic/hall_call_register.sv ====
/*
 * Hall call register
 * Splits hall presses into up and down requests and drives the call lights
 */

`timescale 1ns/1ps
`default_nettype none

module hall_call_register import floor_pkg::*; (
    input  wire logic        clock,
    input  wire logic        reset_n,
    input  wire floor_mask_t floor_call_buttons,
    input  wire floor_t      current_floor,
    request_ctrl_if.hall_side req,
    output      floor_mask_t call_button_lights
);

    floor_mask_t up_q;
    floor_mask_t down_q;
    floor_mask_t up_press;
    floor_mask_t down_press;
    floor_mask_t clear_mask;

    // Calls at the current floor fall into neither set and are dropped
    assign up_press   = floor_call_buttons & floors_above(current_floor);
    assign down_press = floor_call_buttons & floors_below(current_floor);

    assign clear_mask = req.arrive ? floor_bit(req.arrive_floor) : '0;

    //////////////////////////////////////////////////
    // Request latches
    //////////////////////////////////////////////////

    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            up_q   <= '0;
            down_q <= '0;
        end else if (!req.accept) begin
            // Power off drops every hall request
            up_q   <= '0;
            down_q <= '0;
        end else begin
            // Arrival clear wins over a new press on the same floor
            up_q   <= (up_q | up_press) & ~clear_mask;
            down_q <= (down_q | down_press) & ~clear_mask;
        end
    end

    assign req.up_pending   = up_q;
    assign req.down_pending = down_q;

    // One light per floor, either direction
    assign call_button_lights = up_q | down_q;

endmodule

`default_nettype wire

// ==== logic/car_call_register.sv ====
/*
 * Car call register
 * Latches panel destinations and drives the panel lights
 */

`timescale 1ns/1ps
`default_nettype none

module car_call_register import floor_pkg::*; (
    input  wire logic        clock,
    input  wire logic        reset_n,
    input  wire floor_mask_t panel_buttons,
    request_ctrl_if.car_side req,
    output      floor_mask_t panel_button_lights
);

    floor_mask_t car_q;
    floor_mask_t clear_mask;

    assign clear_mask = req.arrive ? floor_bit(req.arrive_floor) : '0;

    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            car_q <= '0;
        end else if (!req.accept) begin
            car_q <= '0;
        end else begin
            // Same priority as the hall side, clear before press
            car_q <= (car_q | panel_buttons) & ~clear_mask;
        end
    end

    assign req.car_pending     = car_q;
    assign panel_button_lights = car_q;

endmodule

`default_nettype wire

// ==== logic/car_dispatcher.sv ====
/*
 * Car dispatcher
 * Candidate set and target floor choice, travel direction and activate
 * Arrival clear, power acceptance and door button gating
 */

`timescale 1ns/1ps
`default_nettype none

module car_dispatcher import floor_pkg::*; (
    input  wire logic       power_switch,
    input  wire logic       emergency_btn,
    input  wire logic       door_open_btn,
    input  wire logic       door_close_btn,
    input  wire car_state_e elevator_state,
    input  wire floor_t     current_floor,
    input  wire dir_e       elevator_direction,
    request_ctrl_if.dispatch_side req,
    output      floor_t     elevator_floor_selector,
    output      dir_e       direction_selector,
    output      logic       activate_elevator,
    output      logic       door_open_allowed,
    output      logic       door_close_allowed
);

    logic        stopped;
    floor_mask_t candidates;
    floor_mask_t above_mask;
    floor_mask_t below_mask;
    floor_t      pick_floor;
    dir_e        pick_dir;

    // Lowest set bit of a mask, 0 when empty
    function automatic floor_t lowest_set(input floor_mask_t m);
        floor_t f;
        f = '0;
        for (int n = NUM_FLOORS - 1; n >= 0; n--) begin
            if (m[n]) begin
                f = floor_t'(n);
            end
        end
        return f;
    endfunction

    // Highest set bit of a mask, 0 when empty
    function automatic floor_t highest_set(input floor_mask_t m);
        floor_t f;
        f = '0;
        for (int n = 0; n < NUM_FLOORS; n++) begin
            if (m[n]) begin
                f = floor_t'(n);
            end
        end
        return f;
    endfunction

    assign stopped    = is_stop_state(elevator_state);
    assign above_mask = floors_above(current_floor);
    assign below_mask = floors_below(current_floor);

    //////////////////////////////////////////////////
    // Candidate set
    //////////////////////////////////////////////////

    // Car calls first, then hall calls in the travel direction, then the rest
    always_comb begin
        if (|req.car_pending) begin
            candidates = req.car_pending;
        end else if (elevator_direction == DIR_UP) begin
            candidates = (|req.up_pending) ? req.up_pending : req.down_pending;
        end else begin
            candidates = (|req.down_pending) ? req.down_pending : req.up_pending;
        end
    end

    //////////////////////////////////////////////////
    // Nearest target in the travel direction
    //////////////////////////////////////////////////

    always_comb begin
        if (elevator_direction == DIR_UP) begin
            if (|(candidates & above_mask)) begin
                pick_floor = lowest_set(candidates & above_mask);
                pick_dir   = DIR_UP;
            end else begin
                // Turn around, includes the current floor
                pick_floor = highest_set(candidates & ~above_mask);
                pick_dir   = DIR_DOWN;
            end
        end else begin
            if (|(candidates & below_mask)) begin
                pick_floor = highest_set(candidates & below_mask);
                pick_dir   = DIR_DOWN;
            end else begin
                pick_floor = lowest_set(candidates & ~below_mask);
                pick_dir   = DIR_UP;
            end
        end
    end

    assign activate_elevator = power_switch && !emergency_btn && stopped && (|candidates);

    // Idle car reports where it is and which way it last went
    assign elevator_floor_selector = activate_elevator ? pick_floor : current_floor;
    assign direction_selector      = activate_elevator ? pick_dir : elevator_direction;

    // Target reached while standing, clear that floor next edge
    assign req.accept       = power_switch;
    assign req.arrive       = activate_elevator && (pick_floor == current_floor);
    assign req.arrive_floor = pick_floor;

    // Doors only respond to a powered, standing car
    assign door_open_allowed  = door_open_btn && power_switch && stopped;
    assign door_close_allowed = door_close_btn && power_switch && stopped;

endmodule

`default_nettype wire

// ==== logic/floor_logic_top.sv ====
/*
 * Top level of the elevator request logic
 * Hall and car call registers feeding the dispatcher over one request bus
 */

`timescale 1ns/1ps
`default_nettype none

module floor_logic_top import floor_pkg::*; (
    input  wire logic        clock,
    input  wire logic        reset_n,
    input  wire floor_mask_t floor_call_buttons,
    input  wire floor_mask_t panel_buttons,
    input  wire logic        door_open_btn,
    input  wire logic        door_close_btn,
    input  wire logic        emergency_btn,
    input  wire logic        power_switch,
    input  wire floor_t      current_floor_state,
    input  wire car_state_e  elevator_state,
    input  wire dir_e        elevator_direction,
    output      floor_t      elevator_floor_selector,
    output      dir_e        direction_selector,
    output      logic        activate_elevator,
    output      floor_mask_t call_button_lights,
    output      floor_mask_t panel_button_lights,
    output      logic        door_open_allowed,
    output      logic        door_close_allowed
);

    request_ctrl_if req ();

    // Hall calls split by direction
    hall_call_register u_hall (
        .clock              (clock),
        .reset_n            (reset_n),
        .floor_call_buttons (floor_call_buttons),
        .current_floor      (current_floor_state),
        .req                (req),
        .call_button_lights (call_button_lights)
    );

    // Destinations from inside the car
    car_call_register u_car (
        .clock               (clock),
        .reset_n             (reset_n),
        .panel_buttons       (panel_buttons),
        .req                 (req),
        .panel_button_lights (panel_button_lights)
    );

    car_dispatcher u_dispatch (
        .power_switch            (power_switch),
        .emergency_btn           (emergency_btn),
        .door_open_btn           (door_open_btn),
        .door_close_btn          (door_close_btn),
        .elevator_state          (elevator_state),
        .current_floor           (current_floor_state),
        .elevator_direction      (elevator_direction),
        .req                     (req),
        .elevator_floor_selector (elevator_floor_selector),
        .direction_selector      (direction_selector),
        .activate_elevator       (activate_elevator),
        .door_open_allowed       (door_open_allowed),
        .door_close_allowed      (door_close_allowed)
    );

endmodule

`default_nettype wire

// ==== verif/floor_logic_assert.sv ====
/*
 * Bound checks on the request logic top-level ports
 * Call latching, power off, activate, target choice, arrival clear, door gating
 */

`timescale 1ns/1ps
`default_nettype none

module floor_logic_assert import floor_pkg::*; (
    input wire logic        clock,
    input wire logic        reset_n,
    input wire floor_mask_t floor_call_buttons,
    input wire floor_mask_t panel_buttons,
    input wire logic        door_open_btn,
    input wire logic        door_close_btn,
    input wire logic        emergency_btn,
    input wire logic        power_switch,
    input wire floor_t      current_floor_state,
    input wire car_state_e  elevator_state,
    input wire dir_e        elevator_direction,
    input wire floor_t      elevator_floor_selector,
    input wire dir_e        direction_selector,
    input wire logic        activate_elevator,
    input wire floor_mask_t call_button_lights,
    input wire floor_mask_t panel_button_lights,
    input wire logic        door_open_allowed,
    input wire logic        door_close_allowed
);

    int               fail_count = 0;
    logic             stopped;
    logic             expect_active;
    logic [1:0]       door_expect;
    logic [FLOOR_W:0] target_expect;
    floor_mask_t      here_bit;
    floor_mask_t      arrive_bit;
    logic             power_q;
    floor_mask_t      panel_q;
    floor_mask_t      hall_q;
    floor_mask_t      hall_here_q;
    floor_mask_t      arrive_q;

    // Nearest car call ahead of the car, else the nearest one behind or here
    // Result is {direction, floor}
    function automatic logic [FLOOR_W:0] car_call_target(input floor_mask_t calls,
                                                          input floor_t cur,
                                                          input dir_e dir);
        int               step;
        int               f;
        logic             found;
        logic [FLOOR_W:0] result;
        step   = (dir == DIR_UP) ? 1 : -1;
        found  = 1'b0;
        result = {dir, cur};
        for (int d = 1; d < NUM_FLOORS; d++) begin
            f = int'(cur) + step * d;
            if (!found && f >= 0 && f < NUM_FLOORS && calls[floor_t'(f)]) begin
                found  = 1'b1;
                result = {dir, floor_t'(f)};
            end
        end
        // Turned around
        for (int d = 0; d < NUM_FLOORS; d++) begin
            f = int'(cur) - step * d;
            if (!found && f >= 0 && f < NUM_FLOORS && calls[floor_t'(f)]) begin
                found  = 1'b1;
                result = {~dir, floor_t'(f)};
            end
        end
        return result;
    endfunction

    assign stopped       = (elevator_state <= STOP_FL11);
    assign here_bit      = floor_mask_t'(1) << current_floor_state;
    assign expect_active = power_switch && !emergency_btn && stopped
                           && ((call_button_lights | panel_button_lights) != '0);
    assign door_expect   = {door_open_btn, door_close_btn} & {2{power_switch && stopped}};
    assign target_expect = car_call_target(panel_button_lights, current_floor_state,
                                           elevator_direction);

    // Standing at the chosen floor clears it on the next edge
    assign arrive_bit = (activate_elevator && elevator_floor_selector == current_floor_state)
                        ? here_bit : '0;

    //////////////////////////////////////////////////
    // What the last edge should have done
    //////////////////////////////////////////////////

    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            power_q     <= 1'b0;
            panel_q     <= '0;
            hall_q      <= '0;
            hall_here_q <= '0;
            arrive_q    <= '0;
        end else begin
            power_q     <= power_switch;
            panel_q     <= panel_buttons & ~arrive_bit;
            hall_q      <= floor_call_buttons & ~here_bit;
            // Dark call at the car's own floor must stay dark
            hall_here_q <= floor_call_buttons & here_bit & ~call_button_lights;
            arrive_q    <= arrive_bit;
        end
    end

    //////////////////////////////////////////////////
    // Checks
    //////////////////////////////////////////////////

    a_panel_latch: assert property (@(posedge clock) disable iff (!reset_n)
        power_q |-> ((panel_button_lights & panel_q) == panel_q))
    else begin
        fail_count++;
        $error("[ERROR] panel_button_lights=%h expected bits %h set", panel_button_lights,
               panel_q);
    end

    a_hall_latch: assert property (@(posedge clock) disable iff (!reset_n)
        power_q |-> ((call_button_lights & hall_q) == hall_q))
    else begin
        fail_count++;
        $error("[ERROR] call_button_lights=%h expected bits %h set", call_button_lights,
               hall_q);
    end

    a_hall_here: assert property (@(posedge clock) disable iff (!reset_n)
        (call_button_lights & hall_here_q) == '0)
    else begin
        fail_count++;
        $error("[ERROR] call_button_lights=%h expected bits %h clear", call_button_lights,
               hall_here_q);
    end

    a_power_off: assert property (@(posedge clock) disable iff (!reset_n)
        !power_q |-> ((call_button_lights | panel_button_lights) == '0))
    else begin
        fail_count++;
        $error("[ERROR] call_button_lights=%h panel_button_lights=%h expected 000",
               call_button_lights, panel_button_lights);
    end

    a_activate: assert property (@(posedge clock) disable iff (!reset_n)
        activate_elevator == expect_active)
    else begin
        fail_count++;
        $error("[ERROR] activate_elevator=%h expected %h", activate_elevator, expect_active);
    end

    a_car_target: assert property (@(posedge clock) disable iff (!reset_n)
        (activate_elevator && panel_button_lights != '0)
            |-> ({direction_selector, elevator_floor_selector} == target_expect))
    else begin
        fail_count++;
        $error("[ERROR] direction_selector,elevator_floor_selector=%h expected %h",
               {direction_selector, elevator_floor_selector}, target_expect);
    end

    a_arrive_clear: assert property (@(posedge clock) disable iff (!reset_n)
        ((call_button_lights | panel_button_lights) & arrive_q) == '0)
    else begin
        fail_count++;
        $error("[ERROR] call_button_lights=%h panel_button_lights=%h expected bits %h clear",
               call_button_lights, panel_button_lights, arrive_q);
    end

    a_doors: assert property (@(posedge clock) disable iff (!reset_n)
        {door_open_allowed, door_close_allowed} == door_expect)
    else begin
        fail_count++;
        $error("[ERROR] door_open_allowed,door_close_allowed=%h expected %h",
               {door_open_allowed, door_close_allowed}, door_expect);
    end

endmodule

`default_nettype wire

// ==== verif/floor_logic_tb.sv ====
/*
 * Testbench for the elevator request logic
 * Clock, reset, directed and random stimulus, failure monitor and timeout
 */

`timescale 1ns/1ps
`default_nettype none

module floor_logic_tb import floor_pkg::*; ();

    localparam int RESET_CYCLES    = 3;
    localparam int DIRECTED_CYCLES = 41;
    localparam int SWEEP_CYCLES    = 64;
    localparam int MAX_CYCLES      = 2 * (RESET_CYCLES + DIRECTED_CYCLES + SWEEP_CYCLES);

    logic        clock;
    logic        reset_n;
    floor_mask_t floor_call_buttons;
    floor_mask_t panel_buttons;
    logic        door_open_btn;
    logic        door_close_btn;
    logic        emergency_btn;
    logic        power_switch;
    floor_t      current_floor_state;
    car_state_e  elevator_state;
    dir_e        elevator_direction;
    floor_t      elevator_floor_selector;
    dir_e        direction_selector;
    logic        activate_elevator;
    floor_mask_t call_button_lights;
    floor_mask_t panel_button_lights;
    logic        door_open_allowed;
    logic        door_close_allowed;

    integer      seed = 32'h2cc8_0b12;
    logic [31:0] rnd;
    int          cycle_count = 0;

    floor_logic_top dut (
        .clock                   (clock),
        .reset_n                 (reset_n),
        .floor_call_buttons      (floor_call_buttons),
        .panel_buttons           (panel_buttons),
        .door_open_btn           (door_open_btn),
        .door_close_btn          (door_close_btn),
        .emergency_btn           (emergency_btn),
        .power_switch            (power_switch),
        .current_floor_state     (current_floor_state),
        .elevator_state          (elevator_state),
        .elevator_direction      (elevator_direction),
        .elevator_floor_selector (elevator_floor_selector),
        .direction_selector      (direction_selector),
        .activate_elevator       (activate_elevator),
        .call_button_lights      (call_button_lights),
        .panel_button_lights     (panel_button_lights),
        .door_open_allowed       (door_open_allowed),
        .door_close_allowed      (door_close_allowed)
    );

    bind floor_logic_top floor_logic_assert u_check (
        .clock                   (clock),
        .reset_n                 (reset_n),
        .floor_call_buttons      (floor_call_buttons),
        .panel_buttons           (panel_buttons),
        .door_open_btn           (door_open_btn),
        .door_close_btn          (door_close_btn),
        .emergency_btn           (emergency_btn),
        .power_switch            (power_switch),
        .current_floor_state     (current_floor_state),
        .elevator_state          (elevator_state),
        .elevator_direction      (elevator_direction),
        .elevator_floor_selector (elevator_floor_selector),
        .direction_selector      (direction_selector),
        .activate_elevator       (activate_elevator),
        .call_button_lights      (call_button_lights),
        .panel_button_lights     (panel_button_lights),
        .door_open_allowed       (door_open_allowed),
        .door_close_allowed      (door_close_allowed)
    );

    initial begin
        clock = 1'b0;
        forever #50 clock = ~clock;
    end

    // Assertion failures and the cycle limit both end the run here
    always @(negedge clock) begin
        cycle_count = cycle_count + 1;
        if (dut.u_check.fail_count != 0) begin
            $display("SOME TESTS FAILED");
            $fatal(1, "An assertion check failed at cycle %0d", cycle_count);
        end else if (cycle_count >= MAX_CYCLES) begin
            $display("Timeout: the test did not finish within %0d cycles", MAX_CYCLES);
            $display("SOME TESTS FAILED");
            $fatal(1, "Run stopped by the cycle limit");
        end
    end

    //////////////////////////////////////////////////
    // Stimulus helpers
    //////////////////////////////////////////////////

    // Wait n rising edges, then step past the edge to drive
    task automatic next_cycle(input int n);
        repeat (n) @(posedge clock);
        #10;
    endtask

    function automatic floor_mask_t mask_of(input int f);
        return floor_mask_t'(1) << f;
    endfunction

    task automatic press_panel(input floor_mask_t m);
        panel_buttons = m;
        next_cycle(1);
        panel_buttons = '0;
    endtask

    task automatic press_hall(input floor_mask_t m);
        floor_call_buttons = m;
        next_cycle(1);
        floor_call_buttons = '0;
    endtask

    // Car standing at floor f
    task automatic park_car(input floor_t f, input dir_e d);
        current_floor_state = f;
        elevator_state      = car_state_e'(STATE_W'(f));
        elevator_direction  = d;
    endtask

    task automatic random_cycle();
        rnd = $random(seed);
        door_open_btn      = rnd[0];
        door_close_btn     = rnd[1];
        power_switch       = |rnd[4:2];
        emergency_btn      = rnd[5] & rnd[6];
        elevator_direction = dir_e'(rnd[7]);
        elevator_state     = car_state_e'({1'b0, rnd[12:8]});
        rnd = $random(seed);
        current_floor_state = floor_t'(rnd % NUM_FLOORS);
        rnd = $random(seed);
        floor_call_buttons = rnd[10:0] & rnd[21:11];
        panel_buttons      = rnd[31:21] & rnd[20:10];
    endtask

    //////////////////////////////////////////////////
    // Test sequence
    //////////////////////////////////////////////////

    initial begin
        reset_n            = 1'b0;
        floor_call_buttons = '0;
        panel_buttons      = '0;
        door_open_btn      = 1'b0;
        door_close_btn     = 1'b0;
        emergency_btn      = 1'b0;
        power_switch       = 1'b0;
        park_car(4'd0, DIR_UP);
        next_cycle(RESET_CYCLES);
        reset_n = 1'b1;

        // Latch calls with dispatch held off, hall call at floor 2 is ignored
        power_switch  = 1'b1;
        emergency_btn = 1'b1;
        park_car(4'd2, DIR_UP);
        next_cycle(1);
        press_panel(mask_of(5) | mask_of(8));
        press_hall(mask_of(0) | mask_of(2) | mask_of(7));
        next_cycle(2);

        // Car call target from several positions and directions
        emergency_btn = 1'b0;
        next_cycle(2);
        elevator_direction = DIR_DOWN;
        next_cycle(2);
        park_car(4'd9, DIR_UP);
        next_cycle(2);
        park_car(4'd9, DIR_DOWN);
        next_cycle(2);
        elevator_state = UP_F5_F6;
        next_cycle(2);

        // Stand at each target so it clears, hall calls remain at the end
        park_car(4'd8, DIR_UP);
        next_cycle(2);
        park_car(4'd5, DIR_DOWN);
        next_cycle(2);
        park_car(4'd0, DIR_DOWN);
        next_cycle(2);
        park_car(4'd7, DIR_UP);
        next_cycle(2);

        press_hall(mask_of(7));
        next_cycle(2);
        // Lights first, then clears on arrival
        press_panel(mask_of(7));
        next_cycle(2);

        emergency_btn = 1'b1;
        press_panel(mask_of(3));
        next_cycle(2);
        emergency_btn = 1'b0;
        next_cycle(2);

        press_hall(mask_of(10));
        power_switch = 1'b0;
        next_cycle(3);
        power_switch = 1'b1;
        next_cycle(1);

        // Random presses, doors and car states, moving states included
        for (int i = 0; i < SWEEP_CYCLES; i++) begin
            random_cycle();
            next_cycle(1);
        end

        floor_call_buttons = '0;
        panel_buttons      = '0;
        door_open_btn      = 1'b0;
        door_close_btn     = 1'b0;
        emergency_btn      = 1'b0;
        power_switch       = 1'b1;
        park_car(4'd0, DIR_UP);
        next_cycle(2);

        if (dut.u_check.fail_count != 0) begin
            $display("SOME TESTS FAILED");
            $fatal(1, "Assertion checks failed %0d times", dut.u_check.fail_count);
        end else begin
            $display("ALL TESTS PASSED");
            $finish;
        end
    end

endmodule

`default_nettype wire

// ==== vlog.f ====
logic/floor_pkg.sv
logic/request_ctrl_if.sv
logic/hall_call_register.sv
logic/car_call_register.sv
logic/car_dispatcher.sv
logic/floor_logic_top.sv
verif/floor_logic_assert.sv
verif/floor_logic_tb.sv

// ==== Makefile ====
VERILATOR = verilator
VFLAGS    = --binary --timing --assert
TOP       = floor_logic_tb
FILELIST  = vlog.f
OBJ_DIR   = obj_dir
RUN_FLAGS = +verilator+error+limit+1000
PASS_TEXT = ALL TESTS PASSED

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench, check for the pass message"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	@out="$$(./$(OBJ_DIR)/V$(TOP) $(RUN_FLAGS) 2>&1)"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_TEXT)"

clean:
	rm -rf $(OBJ_DIR)
